// File: pyonpyon_pkg.sv
package pyonpyon_pkg;

  // --------------------
  // widths and types
  // --------------------
  typedef logic [3:0]  bcd_digit_t;   // one decimal digit, 0..9
  typedef logic [6:0]  seg7_t;        // active low, segment g at bit 6
  typedef logic [32:0] box_seq_t;     // bit 0 is the box in front of the player
  typedef logic [1:0]  speed_t;       // opponent speed select
  typedef logic [27:0] tick_count_t;  // rate divider count, covers 50 MHz

  // --------------------
  // game constants
  // --------------------
  // 0 = left, 1 = right, bit 0 comes first
  localparam box_seq_t box_pattern = 33'b0_1101_0001_0101_1101_1001_0110_1000_1001;

  localparam bcd_digit_t score_start_tens = 4'd3;  // both players start at 32
  localparam bcd_digit_t score_start_ones = 4'd2;

  // opponent speed codes
  localparam speed_t speed_easy    = 2'd0;  // 1.5 steps/s
  localparam speed_t speed_medium  = 2'd1;  // 2 steps/s
  localparam speed_t speed_hard    = 2'd2;  // 3 steps/s
  localparam speed_t speed_extreme = 2'd3;  // 5 steps/s

  localparam int default_clk_hz = 50_000_000;  // board oscillator

endpackage

// File: seg7_decoder.sv
`timescale 1ns/1ps

module seg7_decoder (
  input  pyonpyon_pkg::bcd_digit_t digit,
  output pyonpyon_pkg::seg7_t      segments  // 0 lights a segment
);

  always_comb begin
    case (digit)
      4'd0:    segments = 7'b100_0000;
      4'd1:    segments = 7'b111_1001;
      4'd2:    segments = 7'b010_0100;
      4'd3:    segments = 7'b011_0000;
      4'd4:    segments = 7'b001_1001;
      4'd5:    segments = 7'b001_0010;
      4'd6:    segments = 7'b000_0010;
      4'd7:    segments = 7'b111_1000;
      4'd8:    segments = 7'b000_0000;
      4'd9:    segments = 7'b001_0000;
      default: segments = 7'b100_0000;  // non-decimal codes show 0
    endcase
  end

endmodule

// File: bcd_score_counter.sv
`timescale 1ns/1ps

module bcd_score_counter (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    step,   // count one box off
  output pyonpyon_pkg::bcd_digit_t ones,
  output pyonpyon_pkg::bcd_digit_t tens,
  output logic                    ended   // stepped while at 00
);

  import pyonpyon_pkg::*;

  logic ones_zero;  // borrow needed
  logic tens_zero;

  assign ones_zero = (ones == 4'd0);
  assign tens_zero = (tens == 4'd0);

  // --------------------
  // decimal down count
  // --------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ones  <= score_start_ones;  // 32
      tens  <= score_start_tens;
      ended <= 1'b0;
    end else if (step) begin
      if (!ones_zero) begin
        ones <= ones - 4'd1;      // plain decrement
      end else if (!tens_zero) begin
        ones <= 4'd9;             // borrow from tens
        tens <= tens - 4'd1;
      end else begin
        ended <= 1'b1;            // 00 stays, flag latches until reset
      end
    end
  end

endmodule

// File: box_sequencer.sv
`timescale 1ns/1ps

module box_sequencer (
  input  logic clk,
  input  logic reset,
  input  logic hit,  // one-cycle pulse from key_judge
  output logic box   // current box, 0 = left, 1 = right
);

  import pyonpyon_pkg::*;

  box_seq_t seq;  // remaining boxes, bit 0 in front

  // --------------------
  // shift register
  // --------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      seq <= box_pattern;  // fresh course on restart
    end else if (hit) begin
      seq <= {1'b0, seq[$bits(box_seq_t)-1:1]};  // next box moves to bit 0
    end
  end

  // past the last box the player faces lefts only
  assign box = seq[0];

endmodule

// File: key_judge.sv
`timescale 1ns/1ps

module key_judge (
  input  logic clk,
  input  logic reset,
  input  logic run,        // game enabled
  input  logic finished,   // game over, freeze
  input  logic key_left,   // active high
  input  logic key_right,  // active high
  input  logic box,        // current box from sequencer
  output logic hit         // one pulse per correct press
);

  logic left_q;     // key sample from previous edge
  logic right_q;
  logic new_left;   // rising edge seen this cycle
  logic new_right;
  logic match;      // new press agrees with box
  logic allowed;    // hits only during play

  // --------------------
  // press detection
  // --------------------
  assign new_left  = key_left & ~left_q;
  assign new_right = key_right & ~right_q;

  assign match   = (new_right & box) | (new_left & ~box);  // wrong key falls out here
  assign allowed = run & ~finished;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      left_q  <= 1'b0;
      right_q <= 1'b0;
      hit     <= 1'b0;
    end else begin
      left_q  <= key_left;           // tracked even while stopped
      right_q <= key_right;          // so a held key never counts later
      hit     <= match & allowed;    // high for exactly one cycle
    end
  end

endmodule

// File: pc_pacer.sv
`timescale 1ns/1ps

module pc_pacer #(
  parameter int clk_hz = pyonpyon_pkg::default_clk_hz
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                run,       // game enabled
  input  logic                finished,  // game over, freeze
  input  pyonpyon_pkg::speed_t speed,    // sampled at each reload
  output logic                step       // opponent step pulse
);

  import pyonpyon_pkg::*;

  // --------------------
  // reload values
  // --------------------
  localparam tick_count_t reload_easy    = tick_count_t'(clk_hz * 2 / 3 - 1);  // 1.5 Hz
  localparam tick_count_t reload_medium  = tick_count_t'(clk_hz / 2 - 1);      // 2 Hz
  localparam tick_count_t reload_hard    = tick_count_t'(clk_hz / 3 - 1);      // 3 Hz
  localparam tick_count_t reload_extreme = tick_count_t'(clk_hz / 5 - 1);      // 5 Hz

  tick_count_t count;     // cycles left until next step
  tick_count_t reload;    // period minus one for current speed
  logic        counting;  // divider may run

  assign counting = run & ~finished;

  always_comb begin
    case (speed)
      speed_easy:    reload = reload_easy;
      speed_medium:  reload = reload_medium;
      speed_hard:    reload = reload_hard;
      speed_extreme: reload = reload_extreme;
      default:       reload = reload_easy;
    endcase
  end

  // --------------------
  // down counter
  // --------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= reload_easy;  // first period runs at the easy rate
      step  <= 1'b0;
    end else begin
      step <= 1'b0;
      if (counting) begin
        if (count == '0) begin
          count <= reload;   // new speed picked up here
          step  <= 1'b1;
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

endmodule

// File: game_timer.sv
`timescale 1ns/1ps

module game_timer #(
  parameter int clk_hz = pyonpyon_pkg::default_clk_hz
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    run,       // game enabled
  input  logic                    finished,  // game over, freeze
  output pyonpyon_pkg::bcd_digit_t ones,     // elapsed seconds
  output pyonpyon_pkg::bcd_digit_t tens
);

  import pyonpyon_pkg::*;

  localparam tick_count_t reload_1hz = tick_count_t'(clk_hz - 1);  // one second

  tick_count_t count;     // cycles left in this second
  logic        counting;  // divider and digits may move
  logic        second;    // last cycle of a second

  assign counting = run & ~finished;
  assign second   = counting & (count == '0);

  // --------------------
  // 1 Hz divider
  // --------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= reload_1hz;
    end else if (counting) begin
      count <= (count == '0) ? reload_1hz : count - 1'b1;
    end
  end

  // --------------------
  // seconds 00..99
  // --------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ones <= 4'd0;
      tens <= 4'd0;
    end else if (second) begin
      if (ones == 4'd9) begin
        ones <= 4'd0;                                  // carry into tens
        tens <= (tens == 4'd9) ? 4'd0 : tens + 4'd1;   // 99 wraps to 00
      end else begin
        ones <= ones + 4'd1;
      end
    end
  end

endmodule

// File: pyonpyon_top.sv
`timescale 1ns/1ps

module pyonpyon_top #(
  parameter int clk_hz = pyonpyon_pkg::default_clk_hz
) (
  input  logic                clk,
  input  logic                reset,            // board reset and game restart
  input  logic                run,              // game enable switch
  input  pyonpyon_pkg::speed_t speed,           // opponent rate
  input  logic                key_left,
  input  logic                key_right,
  output logic                box_led,          // current box, 1 = right
  output logic                finished,
  output pyonpyon_pkg::seg7_t  timer_seg_ones,
  output pyonpyon_pkg::seg7_t  timer_seg_tens,
  output pyonpyon_pkg::seg7_t  pc_seg_ones,
  output pyonpyon_pkg::seg7_t  pc_seg_tens,
  output pyonpyon_pkg::seg7_t  player_seg_ones,
  output pyonpyon_pkg::seg7_t  player_seg_tens
);

  import pyonpyon_pkg::*;

  logic       hit;           // correct press
  logic       step;          // opponent tick
  logic       player_ended;
  logic       pc_ended;
  bcd_digit_t timer_ones;
  bcd_digit_t timer_tens;
  bcd_digit_t pc_ones;
  bcd_digit_t pc_tens;
  bcd_digit_t player_ones;
  bcd_digit_t player_tens;

  assign finished = player_ended | pc_ended;  // first to step past 00 ends it

  // --------------------
  // player side
  // --------------------
  key_judge key_judge_i (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .finished  (finished),
    .key_left  (key_left),
    .key_right (key_right),
    .box       (box_led),
    .hit       (hit)
  );

  box_sequencer box_sequencer_i (
    .clk   (clk),
    .reset (reset),
    .hit   (hit),
    .box   (box_led)
  );

  bcd_score_counter player_score_i (
    .clk   (clk),
    .reset (reset),
    .step  (hit),
    .ones  (player_ones),
    .tens  (player_tens),
    .ended (player_ended)
  );

  // --------------------
  // opponent and timer
  // --------------------
  pc_pacer #(.clk_hz(clk_hz)) pc_pacer_i (
    .clk      (clk),
    .reset    (reset),
    .run      (run),
    .finished (finished),
    .speed    (speed),
    .step     (step)
  );

  bcd_score_counter pc_score_i (
    .clk   (clk),
    .reset (reset),
    .step  (step),
    .ones  (pc_ones),
    .tens  (pc_tens),
    .ended (pc_ended)
  );

  game_timer #(.clk_hz(clk_hz)) game_timer_i (
    .clk      (clk),
    .reset    (reset),
    .run      (run),
    .finished (finished),
    .ones     (timer_ones),
    .tens     (timer_tens)
  );

  // --------------------
  // displays
  // --------------------
  seg7_decoder timer_ones_dec_i  (.digit(timer_ones),  .segments(timer_seg_ones));
  seg7_decoder timer_tens_dec_i  (.digit(timer_tens),  .segments(timer_seg_tens));
  seg7_decoder pc_ones_dec_i     (.digit(pc_ones),     .segments(pc_seg_ones));
  seg7_decoder pc_tens_dec_i     (.digit(pc_tens),     .segments(pc_seg_tens));
  seg7_decoder player_ones_dec_i (.digit(player_ones), .segments(player_seg_ones));
  seg7_decoder player_tens_dec_i (.digit(player_tens), .segments(player_seg_tens));

endmodule

// File: tb_pyonpyon.sv
`timescale 1ns/1ps

module tb_pyonpyon;

  import pyonpyon_pkg::*;

  localparam int clk_hz = 60;  // every divider period a whole cycle count
  localparam logic [32:0] course = 33'b0_1101_0001_0101_1101_1001_0110_1000_1001;  // 1 = right
  localparam int sel_player   = 0;  // selectors for read_value
  localparam int sel_pc       = 1;
  localparam int sel_timer    = 2;
  localparam int sel_finished = 3;

  logic   clk;
  logic   reset;
  logic   run;
  speed_t speed;
  logic   key_left;
  logic   key_right;
  logic   box_led;
  logic   finished;
  seg7_t  timer_seg_ones;
  seg7_t  timer_seg_tens;
  seg7_t  pc_seg_ones;
  seg7_t  pc_seg_tens;
  seg7_t  player_seg_ones;
  seg7_t  player_seg_tens;

  int          errors;
  int          tests;
  int          errors_before;  // count when the current test began
  int          box_idx;        // boxes cleared so far
  int          player_exp;     // model player score
  int          cycles;         // length of the last wait
  logic [31:0] rng;

  pyonpyon_top #(.clk_hz(clk_hz)) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // --------------------
  // reference model
  // --------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic int seg_to_digit(input logic [6:0] s);
    case (s)
      7'b100_0000: return 0;
      7'b111_1001: return 1;
      7'b010_0100: return 2;
      7'b011_0000: return 3;
      7'b001_1001: return 4;
      7'b001_0010: return 5;
      7'b000_0010: return 6;
      7'b111_1000: return 7;
      7'b000_0000: return 8;
      7'b001_0000: return 9;
      default:     return 100;  // pushes the value out of 0..99
    endcase
  endfunction

  function automatic int read_value(input int which);
    case (which)
      sel_player: return seg_to_digit(player_seg_tens) * 10 + seg_to_digit(player_seg_ones);
      sel_pc:     return seg_to_digit(pc_seg_tens) * 10 + seg_to_digit(pc_seg_ones);
      sel_timer:  return seg_to_digit(timer_seg_tens) * 10 + seg_to_digit(timer_seg_ones);
      default:    return int'(finished);
    endcase
  endfunction

  function automatic logic expected_box();
    logic [32:0] rest;
    rest = course >> box_idx;  // zeros once the course runs out
    return rest[0];
  endfunction

  // --------------------
  // helpers
  // --------------------
  task automatic next_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #10;  // inputs move just after the edge
    end
  endtask

  task automatic check(input string what, input int got, input int exp);
    assert (got == exp) else begin
      $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic wait_value(input int which, input int target, input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk);  // mid-cycle sample
      n++;
    end while (read_value(which) != target && n < limit);
    cycles = n;
    assert (read_value(which) == target) else begin
      $display("Timeout at %0t ns: output %0d never reached %0d within %0d cycles",
               $time, which, target, limit);
      errors++;
    end
  endtask

  task automatic press(input logic right, input int hold);
    next_cycles(1);
    key_right = right;
    key_left  = ~right;
    next_cycles(hold);
    key_right = 1'b0;
    key_left  = 1'b0;
  endtask

  task automatic good_press(input int hold);
    press(expected_box(), hold);
    box_idx++;
    player_exp--;
    wait_value(sel_player, player_exp, 3);
    check("box_led", int'(box_led), int'(expected_box()));
    next_cycles(3);  // a held key must not count twice
    check("player score", read_value(sel_player), player_exp);
  endtask

  task automatic bad_press(input logic right, input int hold);
    press(right, hold);
    next_cycles(4);
    check("player score", read_value(sel_player), player_exp);
    check("box_led", int'(box_led), int'(expected_box()));
  endtask

  task automatic apply_reset();
    next_cycles(1);
    reset     = 1'b1;
    run       = 1'b0;
    speed     = speed_easy;
    key_left  = 1'b0;
    key_right = 1'b0;
    next_cycles(8);
    reset      = 1'b0;
    box_idx    = 0;
    player_exp = 32;
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == errors_before) begin
      $display("[%s] ok", name);
    end else begin
      $display("[%s] FAILED, %0d errors", name, errors - errors_before);
    end
    errors_before = errors;
  endtask

  // --------------------
  // tests
  // --------------------
  task automatic reset_values();
    apply_reset();
    check("player score", read_value(sel_player), 32);
    check("pc score", read_value(sel_pc), 32);
    check("timer", read_value(sel_timer), 0);
    check("finished", read_value(sel_finished), 0);
    check("box_led", int'(box_led), int'(course[0]));
    finish_test("reset");
  endtask

  task automatic hit_rules();
    int hold;
    apply_reset();
    run = 1'b1;
    repeat (12) begin
      rng  = xorshift(rng);
      hold = 1 + int'(rng[1:0]);
      if (rng[4]) begin
        bad_press(~expected_box(), hold);  // wrong side
      end else begin
        good_press(hold);
      end
    end
    good_press(8);                 // long hold still gives one hit
    run = 1'b0;
    bad_press(expected_box(), 2);  // right key but paused
    finish_test("hits");
  endtask

  task automatic opponent_pace();
    apply_reset();
    speed = speed_extreme;
    run   = 1'b1;
    wait_value(sel_pc, 31, 45);  // first period loaded at reset rate
    wait_value(sel_pc, 30, 20);
    check("extreme step interval", cycles, 12);
    wait_value(sel_pc, 29, 20);
    check("extreme step interval", cycles, 12);
    next_cycles(1);
    speed = speed_easy;
    wait_value(sel_pc, 28, 20);  // reload here takes the easy period
    wait_value(sel_pc, 27, 50);
    check("easy step interval", cycles, 40);
    wait_value(sel_pc, 26, 50);
    check("easy step interval", cycles, 40);
    check("player score", read_value(sel_player), 32);
    finish_test("pace");
  endtask

  task automatic timer_hold();
    apply_reset();
    run = 1'b1;
    wait_value(sel_timer, 1, 70);
    wait_value(sel_timer, 2, 70);
    check("second length", cycles, 60);
    next_cycles(25);  // 25 counting edges into the second
    run = 1'b0;
    next_cycles(40);  // longer than the 35 edges left in this second
    check("timer while paused", read_value(sel_timer), 2);
    run = 1'b1;
    wait_value(sel_timer, 3, 70);
    check("second across pause", cycles, 36);  // 35 edges left plus the sample before them
    finish_test("timer");
  endtask

  task automatic player_finish();
    int pc_val;
    int timer_val;
    apply_reset();
    run = 1'b1;
    repeat (32) good_press(1);
    press(expected_box(), 1);  // one step past 00
    wait_value(sel_finished, 1, 4);
    check("player score", read_value(sel_player), 0);
    pc_val    = read_value(sel_pc);
    timer_val = read_value(sel_timer);
    press(1'b1, 2);
    press(1'b0, 2);
    next_cycles(100);  // longer than any divider period
    check("player frozen", read_value(sel_player), 0);
    check("pc frozen", read_value(sel_pc), pc_val);
    check("timer frozen", read_value(sel_timer), timer_val);
    check("finished held", read_value(sel_finished), 1);
    finish_test("finish");
  endtask

  initial begin
    errors        = 0;
    tests         = 0;
    errors_before = 0;
    rng           = 32'h8484;
    reset         = 1'b0;
    run           = 1'b0;
    speed         = speed_easy;
    key_left      = 1'b0;
    key_right     = 1'b0;
    reset_values();
    hit_rules();
    opponent_pace();
    timer_hold();
    player_finish();
    $display("tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: pyonpyon_top.f
pyonpyon_pkg.sv
seg7_decoder.sv
bcd_score_counter.sv
box_sequencer.sv
key_judge.sv
pc_pacer.sv
game_timer.sv
pyonpyon_top.sv
tb_pyonpyon.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   ?= pyonpyon_top.f
RTL_TOP    ?= pyonpyon_top
TB_TOP     ?= tb_pyonpyon
TB_SRC     ?= tb_pyonpyon.sv
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Test failed
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

SRCS     = $(shell cat $(FILELIST))
RTL_SRCS = $(filter-out $(TB_SRC),$(SRCS))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(BUILD_DIR)/V$(TB_TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
